//--- ion_pkg.sv
/* Ion sensor packet definitions */
`default_nettype none

package ion_pkg;

	localparam int num_samples = 60;
	localparam int index_width = 6;

	// Widths of the fixed header and trailer fields
	localparam int device_id_width = 7;
	localparam int byte_width = 8;
	localparam int word_width = 16;
	localparam int format_width = 6;
	localparam int serial_width = 24;

	typedef logic [index_width-1:0] sample_index_t;

	// Per-sample fields, 49 bits
	typedef struct packed {
		logic polarity;
		logic [byte_width-1:0] level;
		logic [byte_width-1:0] gain;
		logic [word_width-1:0] timestamp;
		logic [word_width-1:0] raw_value;
	} ion_sample_t;

	// Full 110-bit packet, device_id in the low bits
	typedef struct packed {
		logic [serial_width-1:0] serial_number;
		logic [format_width-1:0] format_version;
		logic [word_width-1:0] raw_value;
		logic [byte_width-1:0] marker_lo;
		logic [byte_width-1:0] marker_hi;
		logic [word_width-1:0] timestamp;
		logic [byte_width-1:0] gain;
		logic [byte_width-1:0] level;
		logic [byte_width-1:0] sync_byte;
		logic polarity;
		logic [device_id_width-1:0] device_id;
	} ion_packet_t;

	localparam logic [device_id_width-1:0] device_id_value = 7'd77;
	localparam logic [byte_width-1:0] sync_value = 8'd255;
	localparam logic [byte_width-1:0] marker_hi_value = 8'd239;
	localparam logic [byte_width-1:0] marker_lo_value = 8'd17;
	localparam logic [format_width-1:0] format_value = 6'd1;
	localparam logic [serial_width-1:0] serial_value = 24'd4272433;

endpackage

`default_nettype wire

//--- ion_sample_rom.sv
/* Recorded ion sample table */
`default_nettype none

module ion_sample_rom (
	input ion_pkg::sample_index_t sample_index,
	output ion_pkg::ion_sample_t sample
);

	// polarity, level, gain, timestamp, raw_value
	always_comb
	begin
		case (sample_index)
			6'd0: sample = '{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110};
			6'd1: sample = '{1'b1, 8'd176, 8'd100, 16'd925, 16'd3791};
			6'd2: sample = '{1'b0, 8'd177, 8'd100, 16'd962, 16'd63275};
			6'd3: sample = '{1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574};
			6'd4: sample = '{1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019};
			6'd5: sample = '{1'b1, 8'd186, 8'd100, 16'd1094, 16'd50527};
			6'd6: sample = '{1'b0, 8'd177, 8'd100, 16'd1136, 16'd60177};
			6'd7: sample = '{1'b0, 8'd178, 8'd100, 16'd1178, 16'd47222};
			6'd8: sample = '{1'b0, 8'd177, 8'd100, 16'd1220, 16'd42756};
			6'd9: sample = '{1'b0, 8'd177, 8'd100, 16'd1262, 16'd61961};
			6'd10: sample = '{1'b0, 8'd183, 8'd100, 16'd1304, 16'd7993};
			6'd11: sample = '{1'b0, 8'd178, 8'd100, 16'd1346, 16'd17675};
			6'd12: sample = '{1'b0, 8'd178, 8'd100, 16'd1380, 16'd57473};
			6'd13: sample = '{1'b0, 8'd177, 8'd100, 16'd1430, 16'd53224};
			6'd14: sample = '{1'b0, 8'd178, 8'd100, 16'd1472, 16'd61195};
			6'd15: sample = '{1'b1, 8'd185, 8'd100, 16'd1514, 16'd46996};
			6'd16: sample = '{1'b1, 8'd177, 8'd100, 16'd1556, 16'd145};
			6'd17: sample = '{1'b1, 8'd178, 8'd100, 16'd1598, 16'd21191};
			6'd18: sample = '{1'b0, 8'd177, 8'd100, 16'd1635, 16'd610};
			6'd19: sample = '{1'b1, 8'd177, 8'd100, 16'd1679, 16'd4089};
			6'd20: sample = '{1'b0, 8'd178, 8'd100, 16'd1729, 16'd20685};
			6'd21: sample = '{1'b1, 8'd177, 8'd100, 16'd1766, 16'd10459};
			6'd22: sample = '{1'b1, 8'd178, 8'd100, 16'd1815, 16'd57766};
			6'd23: sample = '{1'b0, 8'd177, 8'd100, 16'd1857, 16'd48236};
			6'd24: sample = '{1'b1, 8'd177, 8'd100, 16'd1903, 16'd36453};
			6'd25: sample = '{1'b0, 8'd183, 8'd100, 16'd1945, 16'd22977};
			6'd26: sample = '{1'b0, 8'd177, 8'd100, 16'd1987, 16'd13045};
			6'd27: sample = '{1'b0, 8'd177, 8'd100, 16'd2033, 16'd40993};
			6'd28: sample = '{1'b1, 8'd177, 8'd100, 16'd2075, 16'd45310};
			6'd29: sample = '{1'b1, 8'd177, 8'd100, 16'd2108, 16'd62988};
			6'd30: sample = '{1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032};
			6'd31: sample = '{1'b1, 8'd178, 8'd100, 16'd2199, 16'd22312};
			6'd32: sample = '{1'b0, 8'd177, 8'd100, 16'd2248, 16'd48507};
			6'd33: sample = '{1'b0, 8'd178, 8'd101, 16'd2286, 16'd3615};
			6'd34: sample = '{1'b1, 8'd177, 8'd100, 16'd2335, 16'd31043};
			6'd35: sample = '{1'b0, 8'd177, 8'd100, 16'd2381, 16'd65151};
			6'd36: sample = '{1'b0, 8'd177, 8'd100, 16'd2423, 16'd45123};
			6'd37: sample = '{1'b0, 8'd177, 8'd100, 16'd2465, 16'd47297};
			6'd38: sample = '{1'b0, 8'd177, 8'd100, 16'd2498, 16'd1374};
			6'd39: sample = '{1'b0, 8'd180, 8'd100, 16'd2548, 16'd8510};
			6'd40: sample = '{1'b1, 8'd178, 8'd100, 16'd2581, 16'd3766};
			6'd41: sample = '{1'b0, 8'd178, 8'd100, 16'd2631, 16'd15678};
			6'd42: sample = '{1'b0, 8'd178, 8'd100, 16'd2670, 16'd46144};
			6'd43: sample = '{1'b1, 8'd176, 8'd100, 16'd2712, 16'd43275};
			6'd44: sample = '{1'b1, 8'd185, 8'd100, 16'd2758, 16'd6402};
			6'd45: sample = '{1'b0, 8'd178, 8'd100, 16'd2800, 16'd28324};
			6'd46: sample = '{1'b0, 8'd177, 8'd100, 16'd2842, 16'd41123};
			6'd47: sample = '{1'b0, 8'd178, 8'd100, 16'd2888, 16'd25754};
			6'd48: sample = '{1'b1, 8'd177, 8'd100, 16'd2926, 16'd43754};
			6'd49: sample = '{1'b0, 8'd177, 8'd100, 16'd2973, 16'd37758};
			6'd50: sample = '{1'b0, 8'd177, 8'd100, 16'd3015, 16'd62364};
			6'd51: sample = '{1'b1, 8'd177, 8'd100, 16'd3057, 16'd48200};
			6'd52: sample = '{1'b1, 8'd178, 8'd100, 16'd3100, 16'd56276};
			6'd53: sample = '{1'b0, 8'd178, 8'd100, 16'd3146, 16'd59933};
			6'd54: sample = '{1'b0, 8'd177, 8'd101, 16'd3184, 16'd30250};
			6'd55: sample = '{1'b1, 8'd178, 8'd100, 16'd3233, 16'd49966};
			6'd56: sample = '{1'b1, 8'd177, 8'd100, 16'd3267, 16'd662};
			6'd57: sample = '{1'b1, 8'd178, 8'd100, 16'd3308, 16'd47031};
			6'd58: sample = '{1'b1, 8'd178, 8'd100, 16'd3349, 16'd2734};
			6'd59: sample = '{1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121};
			default: sample = '0; // Past the last recording
		endcase
	end

endmodule

`default_nettype wire

//--- ion_interval_timer.sv
/* Sampling interval timer */
`default_nettype none

module ion_interval_timer #(
	parameter int interval = 16
) (
	input logic clock,
	input logic resetn,
	input logic run,
	output logic done
);

	localparam int count_width = (interval > 1) ? $clog2(interval) : 1;
	localparam logic [count_width-1:0] last_count = count_width'(interval - 1);

	logic [count_width-1:0] count;

	// Terminal count only counts while running
	assign done = run && (count == last_count);

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			count <= '0;
		else if (!run || done)
			count <= '0;
		else
			count <= count + 1'b1;
	end

endmodule

`default_nettype wire

//--- ion_packet_assembler.sv
/* Outgoing packet register */
`default_nettype none

module ion_packet_assembler (
	input logic clock,
	input logic resetn,
	input logic load,
	input ion_pkg::ion_sample_t sample,
	output ion_pkg::ion_packet_t packet
);

	import ion_pkg::*;

	ion_packet_t next_packet;

	always_comb
	begin
		next_packet.device_id = device_id_value;
		next_packet.polarity = sample.polarity;
		next_packet.sync_byte = sync_value;
		next_packet.level = sample.level;
		next_packet.gain = sample.gain;
		next_packet.timestamp = sample.timestamp;
		next_packet.marker_hi = marker_hi_value; // Fixed trailer
		next_packet.marker_lo = marker_lo_value;
		next_packet.raw_value = sample.raw_value;
		next_packet.format_version = format_value;
		next_packet.serial_number = serial_value;
	end

	// Held until the next load
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			packet <= '0;
		else if (load)
			packet <= next_packet;
	end

endmodule

`default_nettype wire

//--- ion_sensor_ctrl.sv
/* Packet sequencer and handshake */
`default_nettype none

module ion_sensor_ctrl (
	input logic clock,
	input logic resetn,
	input logic timer_done,
	input logic ack,
	output logic timer_run,
	output logic load,
	output ion_pkg::sample_index_t sample_index,
	output logic req
);

	import ion_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,
		st_send,
		st_release
	} state_t;

	state_t state;
	state_t next_state;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (timer_done)
					next_state = st_fetch;
			st_fetch: next_state = st_send;
			st_send:
				if (ack)
					next_state = st_release; // Drops req next cycle
			st_release:
				if (!ack)
					next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// Advance as the packet is registered
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			sample_index <= '0;
		else if (load)
		begin
			if (sample_index == sample_index_t'(num_samples - 1))
				sample_index <= '0;
			else
				sample_index <= sample_index + 1'b1;
		end
	end

	assign timer_run = (state == st_idle); // Timer halts during handshake
	assign load = (state == st_fetch);
	assign req = (state == st_send);

endmodule

`default_nettype wire

//--- ion_sensor.sv
/* Ion sensor replay top level */
`default_nettype none

module ion_sensor #(
	parameter int interval = 16
) (
	input logic clock,
	input logic resetn,
	input logic ack,
	output logic req,
	output ion_pkg::ion_packet_t data_out
);

	import ion_pkg::*;

	logic timer_run;
	logic timer_done;
	logic load;
	sample_index_t sample_index;
	ion_sample_t sample;

	ion_sensor_ctrl i_ion_sensor_ctrl (
		.clock(clock),
		.resetn(resetn),
		.timer_done(timer_done),
		.ack(ack),
		.timer_run(timer_run),
		.load(load),
		.sample_index(sample_index),
		.req(req)
	);

	ion_interval_timer #(
		.interval(interval)
	) i_ion_interval_timer (
		.clock(clock),
		.resetn(resetn),
		.run(timer_run),
		.done(timer_done)
	);

	ion_sample_rom i_ion_sample_rom (
		.sample_index(sample_index),
		.sample(sample)
	);

	ion_packet_assembler i_ion_packet_assembler (
		.clock(clock),
		.resetn(resetn),
		.load(load),
		.sample(sample),
		.packet(data_out)
	);

endmodule

`default_nettype wire

//--- ion_tb_table.svh
/* Checked packet table */
`ifndef ion_tb_table_svh
`define ion_tb_table_svh

// Columns: packet number, expected sample fields
// (polarity, level, gain, timestamp, raw_value), ack delay in cycles
localparam int num_rows = 9;

localparam check_row_t check_rows [num_rows] = '{
	'{0, '{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110}, 0},
	'{1, '{1'b1, 8'd176, 8'd100, 16'd925, 16'd3791}, 3},
	'{2, '{1'b0, 8'd177, 8'd100, 16'd962, 16'd63275}, 7},
	'{3, '{1'b1, 8'd177, 8'd100, 16'd1011, 16'd24574}, 1},
	'{4, '{1'b1, 8'd185, 8'd100, 16'd1045, 16'd40019}, 5},
	'{30, '{1'b1, 8'd177, 8'd101, 16'd2162, 16'd50032}, 2},
	'{58, '{1'b1, 8'd178, 8'd100, 16'd3349, 16'd2734}, 6},
	'{59, '{1'b0, 8'd177, 8'd101, 16'd3390, 16'd36121}, 4},
	'{60, '{1'b0, 8'd177, 8'd100, 16'd881, 16'd56110}, 0} // Wrapped to entry 0
};

`endif

//--- ion_tb.sv
/* Ion sensor testbench */
`default_nettype none

module ion_tb;

	import ion_pkg::*;

	localparam int interval = 16;
	localparam int num_packets = 61;
	localparam int cycle_limit = num_packets * (interval + 20) + 100;

	typedef struct packed {
		int packet_num;
		ion_sample_t sample;
		int ack_delay;
	} check_row_t;

	`include "ion_tb_table.svh"

	logic clock;
	logic resetn;
	logic ack;
	logic req;
	ion_packet_t data_out;

	integer seed = 79010;
	int cycle_count = 0;

	ion_sensor #(
		.interval(interval)
	) i_ion_sensor (
		.clock(clock),
		.resetn(resetn),
		.ack(ack),
		.req(req),
		.data_out(data_out)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	task automatic stop_with_failure;
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_packet(input string name, input ion_packet_t expected,
		input ion_packet_t actual);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Sample point, also where inputs change
	task automatic next_cycle;
		@(posedge clock);
		#10;
	endtask

	function automatic int find_row(input int packet_num);
		int found;
		found = -1;
		for (int i = 0; i < num_rows; i++)
			if (check_rows[i].packet_num == packet_num)
				found = i;
		return found;
	endfunction

	function automatic ion_packet_t with_constants(input ion_packet_t base);
		ion_packet_t result;
		result = base;
		result.device_id = device_id_value;
		result.sync_byte = sync_value;
		result.marker_hi = marker_hi_value;
		result.marker_lo = marker_lo_value;
		result.format_version = format_value;
		result.serial_number = serial_value;
		return result;
	endfunction

	always @(posedge clock)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout: %0d cycles passed before all packets were seen", cycle_count);
			stop_with_failure();
		end
	end

	initial
	begin
		ion_packet_t expected;
		ion_packet_t held;
		logic [15:0] prev_timestamp;
		int row;
		int delay;

		resetn = 1'b0;
		ack = 1'b0;
		prev_timestamp = '0;
		repeat (3) @(posedge clock);
		#10;
		resetn = 1'b1;
		check_bit("req", 1'b0, req);

		for (int p = 0; p < num_packets; p++)
		begin
			while (req !== 1'b1)
			begin
				if (p == 0)
					check_packet("data_out", '0, data_out); // Nothing loaded yet
				next_cycle();
			end

			held = data_out;
			row = find_row(p);
			expected = with_constants(data_out);
			if (row >= 0)
			begin
				expected.polarity = check_rows[row].sample.polarity;
				expected.level = check_rows[row].sample.level;
				expected.gain = check_rows[row].sample.gain;
				expected.timestamp = check_rows[row].sample.timestamp;
				expected.raw_value = check_rows[row].sample.raw_value;
				delay = check_rows[row].ack_delay;
			end
			else
				delay = {$random(seed)} % 8;
			check_packet("data_out", expected, data_out);
			if ((p % num_samples != 0) && (data_out.timestamp <= prev_timestamp))
			begin
				$display("Timestamp of packet %0d did not increase over the one before", p);
				stop_with_failure();
			end
			prev_timestamp = data_out.timestamp;

			// Slow consumer holds the packet
			repeat (delay)
			begin
				next_cycle();
				check_bit("req", 1'b1, req);
				check_packet("data_out", held, data_out);
			end
			ack = 1'b1;
			next_cycle();
			check_bit("req", 1'b0, req);
			check_packet("data_out", held, data_out);
			next_cycle();
			check_bit("req", 1'b0, req); // ack still high
			ack = 1'b0;
			next_cycle();
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- ion_sensor.f
+incdir+.
ion_pkg.sv
ion_sample_rom.sv
ion_interval_timer.sv
ion_packet_assembler.sv
ion_sensor_ctrl.sv
ion_sensor.sv
ion_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ion sensor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ion_tb -f ion_sensor.f -o ion_tb_sim \
	&& ./obj_dir/ion_tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
